/* Makefile */
# Verilator build and run of the intersection controller testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench, fail unless the log reports a pass"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -Idesign -f filelist.f \
		--top-module intersection_tb -o intersection_sim
	./obj_dir/intersection_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* design/intersection_top.sv */
// Four-way intersection controller
// Chains the one second time base, the phase sequencer and the signal head
// decoder so that the lamps follow the phase register directly

`timescale 1ns/1ps

module intersection_top (
	input  logic           clk,
	input  logic           reset,
	input  logic           left_turn_key,
	input  logic           emergency,
	output tl_pkg::light_t nb_light,
	output tl_pkg::light_t sb_light,
	output tl_pkg::light_t eb_light,
	output tl_pkg::light_t wb_light,
	output logic           left_turn_pending
);

	import tl_pkg::*;

	logic   tick; // One cycle pulse per simulated second
	phase_t phase;

	second_tick tick_i (
		.clk  (clk),
		.reset(reset),
		.tick (tick)
	);

	phase_sequencer sequencer_i (
		.clk              (clk),
		.reset            (reset),
		.tick             (tick),
		.emergency        (emergency),
		.left_turn_key    (left_turn_key),
		.phase            (phase),
		.left_turn_pending(left_turn_pending)
	);

	signal_heads heads_i (
		.phase   (phase),
		.nb_light(nb_light),
		.sb_light(sb_light),
		.eb_light(eb_light),
		.wb_light(wb_light)
	);

endmodule

/* design/phase_sequencer.sv */
// Intersection phase sequencer
// Steps through the fixed light cycle with a per phase countdown, inserts
// the southbound arrow phase on a latched request and holds east-west green
// while the emergency input is high

`timescale 1ns/1ps
`include "tl_settings.svh"

module phase_sequencer (
	input  logic           clk,
	input  logic           reset,
	input  logic           tick,
	input  logic           emergency,
	input  logic           left_turn_key,
	output tl_pkg::phase_t phase,
	output logic           left_turn_pending
);

	import tl_pkg::*;

	localparam int timer_w = `TL_TIMER_W;

	typedef logic [timer_w-1:0] timer_t;

	timer_t timer; // Seconds left in the current phase
	phase_t next_phase;
	logic   hold; // Emergency freeze of east-west green
	logic   advance; // Phase changes on this edge
	logic   enter_left;

	// Length of a phase in seconds, loaded on entry
	function automatic timer_t duration(input phase_t p);
		case (p)
			ew_green, ns_green: begin
				duration = timer_t'(`TL_GREEN_SEC);
			end
			ew_yellow, ns_yellow: begin
				duration = timer_t'(`TL_YELLOW_SEC);
			end
			left_arrow: begin
				duration = timer_t'(`TL_LEFT_SEC);
			end
			default: begin
				duration = timer_t'(`TL_ALL_RED_SEC); // Both clearance phases
			end
		endcase
	endfunction

	always_comb begin
		case (phase)
			ew_green: begin
				next_phase = ew_yellow;
			end
			ew_yellow: begin
				next_phase = ew_all_red;
			end
			ew_all_red: begin
				next_phase = left_turn_pending ? left_arrow : ns_green; // Arrow only on request
			end
			left_arrow: begin
				next_phase = ns_green; // Request is already cleared on arrow entry
			end
			ns_green: begin
				next_phase = ns_yellow;
			end
			ns_yellow: begin
				next_phase = ns_all_red;
			end
			default: begin
				next_phase = ew_green; // Also recovers from an invalid encoding
			end
		endcase
	end

	assign hold       = emergency && (phase == ew_green);
	assign advance    = (timer == timer_t'(1)) && !hold;
	assign enter_left = advance && (next_phase == left_arrow);

	// The last second ends on the first edge that sees a count of one
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			phase <= ew_green;
			timer <= duration(ew_green);
		end else if (advance) begin
			phase <= next_phase;
			timer <= duration(next_phase);
		end else if (tick && !hold && (timer > timer_t'(1))) begin
			timer <= timer - timer_t'(1); // Paused while emergency holds green
		end
	end

	// Left turn request from the active low detector key
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			left_turn_pending <= 1'b0;
		end else if (!left_turn_key) begin
			left_turn_pending <= 1'b1; // A new press wins over the clear
		end else if (enter_left) begin
			left_turn_pending <= 1'b0;
		end
	end

endmodule

/* design/second_tick.sv */
// One second time base
// Free running prescaler that divides the clock by tick_div and gives a
// single cycle pulse at the end of every simulated second

`timescale 1ns/1ps
`include "tl_settings.svh"

module second_tick #(
	parameter int tick_div = `TL_TICK_DIV
) (
	input  logic clk,
	input  logic reset,
	output logic tick
);

	localparam int cnt_w = $clog2(tick_div);

	logic [cnt_w-1:0] count;
	logic             last; // Final cycle of the current second

	assign last = (count == cnt_w'(tick_div - 1));

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			count <= '0;
			tick  <= 1'b0;
		end else begin
			count <= last ? '0 : count + cnt_w'(1); // Wrap at the end of a second
			tick  <= last; // Pulse lands tick_div cycles after reset release
		end
	end

endmodule

/* design/signal_heads.sv */
// Signal head decoder
// Turns the current phase into the lamp code shown on each of the four
// approaches, with no added latency

`timescale 1ns/1ps

module signal_heads (
	input  tl_pkg::phase_t phase,
	output tl_pkg::light_t nb_light,
	output tl_pkg::light_t sb_light,
	output tl_pkg::light_t eb_light,
	output tl_pkg::light_t wb_light
);

	import tl_pkg::*;

	always_comb begin
		case (phase)
			ew_green: begin
				nb_light = red;
				sb_light = red;
				eb_light = green;
				wb_light = green;
			end
			ew_yellow: begin
				nb_light = red;
				sb_light = red;
				eb_light = yellow;
				wb_light = yellow;
			end
			ew_all_red, ns_all_red: begin
				nb_light = red; // Clearance between the two directions
				sb_light = red;
				eb_light = red;
				wb_light = red;
			end
			left_arrow: begin
				nb_light = red; // Opposing traffic stopped for the turn
				sb_light = red_arrow;
				eb_light = red;
				wb_light = red;
			end
			ns_green: begin
				nb_light = green;
				sb_light = green;
				eb_light = red;
				wb_light = red;
			end
			ns_yellow: begin
				nb_light = yellow;
				sb_light = yellow;
				eb_light = red;
				wb_light = red;
			end
			default: begin
				nb_light = dark; // Invalid phase leaves every head dark
				sb_light = dark;
				eb_light = dark;
				wb_light = dark;
			end
		endcase
	end

endmodule

/* design/tl_pkg.sv */
// Shared types of the intersection controller
// Holds the phase encoding of the sequencer and the lamp code of a
// signal head

package tl_pkg;

	// Phases in the order the sequencer visits them
	typedef enum logic [2:0] {
		ew_green   = 3'd0, // East and west through traffic
		ew_yellow  = 3'd1,
		ew_all_red = 3'd2,
		left_arrow = 3'd3, // Only taken on a pending request
		ns_green   = 3'd4, // North and south through traffic
		ns_yellow  = 3'd5,
		ns_all_red = 3'd6
	} phase_t;

	// Lamp code of one approach in red, yellow, green bit order
	typedef enum logic [2:0] {
		dark      = 3'b000, // Shown only for an invalid phase
		green     = 3'b001,
		yellow    = 3'b010,
		red       = 3'b100,
		red_arrow = 3'b101 // Red ball with the left arrow lit
	} light_t;

endpackage

/* design/tl_settings.svh */
// Timing constants for the four-way intersection controller
// Durations are counted in simulated seconds, and one second is a fixed
// number of clock cycles taken from the prescaler

`ifndef TL_SETTINGS_SVH
`define TL_SETTINGS_SVH

// Countdown width wide enough for the longest phase
`define TL_TIMER_W 6

// Clock cycles per simulated second
`define TL_TICK_DIV 4

// Through traffic green time
`define TL_GREEN_SEC 60

// Yellow time before the clearance interval
`define TL_YELLOW_SEC 6

// Clearance with every approach red
`define TL_ALL_RED_SEC 2

// Southbound advanced left turn arrow
`define TL_LEFT_SEC 20

`endif

/* filelist.f */
+incdir+design
design/tl_pkg.sv
design/second_tick.sv
design/phase_sequencer.sv
design/signal_heads.sv
design/intersection_top.sv
verification/intersection_assert.sv
verification/intersection_tb.sv

/* verification/intersection_assert.sv */
// Safety assertions for the intersection controller
// Watches for conflicting movements, dark heads and a left turn request
// that clears without the arrow being shown

`timescale 1ns/1ps

module intersection_assert (
	input logic           clk,
	input logic           reset,
	input tl_pkg::light_t nb_light,
	input tl_pkg::light_t sb_light,
	input tl_pkg::light_t eb_light,
	input tl_pkg::light_t wb_light,
	input logic           left_turn_pending
);

	import tl_pkg::*;

	logic ns_moving; // North-south traffic may enter
	logic ew_moving;

	assign ns_moving = (nb_light inside {green, yellow}) || (sb_light inside {green, yellow});
	assign ew_moving = (eb_light inside {green, yellow}) || (wb_light inside {green, yellow});

	no_conflict: assert property (@(posedge clk) disable iff (!reset)
		!(ns_moving && ew_moving))
		else $error("North-south and east-west are released at the same time");

	always_lit: assert property (@(posedge clk) disable iff (!reset)
		nb_light != dark && sb_light != dark && eb_light != dark && wb_light != dark)
		else $error("A signal head went dark");

	clear_on_arrow: assert property (@(posedge clk) disable iff (!reset)
		$fell(left_turn_pending) |-> (sb_light == red_arrow && $past(sb_light) != red_arrow))
		else $error("Left turn request cleared without the arrow phase starting");

endmodule

bind intersection_top intersection_assert assert_i (
	.clk              (clk),
	.reset            (reset),
	.nb_light         (nb_light),
	.sb_light         (sb_light),
	.eb_light         (eb_light),
	.wb_light         (wb_light),
	.left_turn_pending(left_turn_pending)
);

/* verification/intersection_tb.sv */
// Testbench for the four-way intersection controller
// Runs plain cycles, left turn requests and an emergency hold while a
// reference model follows the phase order, lamp codes and phase lengths

`timescale 1ns/1ps
`include "tl_settings.svh"

module intersection_tb;

	import tl_pkg::*;

	localparam int tick_div = `TL_TICK_DIV;
	localparam int margin   = 3 * `TL_TICK_DIV; // Extra cycles allowed on any wait

	logic   clk;
	logic   reset;
	logic   left_turn_key;
	logic   emergency;
	light_t nb_light;
	light_t sb_light;
	light_t eb_light;
	light_t wb_light;
	logic   left_turn_pending;

	int     seed = 32'hd97aa498;
	logic   monitor_on;
	phase_t cur_phase; // Phase the reference model believes is shown
	int     in_phase; // Cycles spent in cur_phase so far
	int     held; // Cycles of east-west green frozen by emergency
	logic   model_pending;
	logic   key_seen; // Key level that the coming clock edge samples

	intersection_top intersection_i (
		.clk              (clk),
		.reset            (reset),
		.left_turn_key    (left_turn_key),
		.emergency        (emergency),
		.nb_light         (nb_light),
		.sb_light         (sb_light),
		.eb_light         (eb_light),
		.wb_light         (wb_light),
		.left_turn_pending(left_turn_pending)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic int phase_seconds(input phase_t p);
		case (p)
			ew_green, ns_green: return `TL_GREEN_SEC;
			ew_yellow, ns_yellow: return `TL_YELLOW_SEC;
			left_arrow: return `TL_LEFT_SEC;
			default: return `TL_ALL_RED_SEC;
		endcase
	endfunction

	function automatic phase_t expected_next(input phase_t p, input logic pending);
		case (p)
			ew_green: return ew_yellow;
			ew_yellow: return ew_all_red;
			ew_all_red: return pending ? left_arrow : ns_green;
			left_arrow: return ns_green;
			ns_green: return ns_yellow;
			ns_yellow: return ns_all_red;
			default: return ew_green;
		endcase
	endfunction

	// Lamp codes packed as nb, sb, eb, wb
	function automatic logic [11:0] expected_lights(input phase_t p);
		case (p)
			ew_green: return {red, red, green, green};
			ew_yellow: return {red, red, yellow, yellow};
			left_arrow: return {red, red_arrow, red, red};
			ns_green: return {green, green, red, red};
			ns_yellow: return {yellow, yellow, red, red};
			default: return {red, red, red, red}; // Both clearance phases
		endcase
	endfunction

	// Allowed stay in cycles around the nominal phase length
	function automatic int window_lo(input phase_t p);
		return (phase_seconds(p) - 2) * tick_div;
	endfunction

	function automatic int window_hi(input phase_t p);
		return phase_seconds(p) * tick_div;
	endfunction

	task automatic report_error(input string msg);
		$display("CHECK FAILED at %0d ns: %s", $time, msg);
		$display("TEST FAIL");
		$fatal(1, "Stopped at the first failed check");
	endtask

	task automatic never_arrived(input phase_t p);
		$display("Gave up waiting: phase %s never arrived", p.name());
		$display("TEST FAIL");
		$fatal(1, "Stopped on a timeout");
	endtask

	// Reference model sampled on the falling edge where every output is settled
	always @(negedge clk) begin
		logic [11:0] shown;
		phase_t      nxt;
		int          lo;
		int          hi;
		logic        entered;
		if (!monitor_on) begin
			cur_phase     = ew_green; // Reset state of the sequencer
			in_phase      = 0;
			held          = 0;
			model_pending = 1'b0;
			key_seen      = left_turn_key;
		end else begin
			shown   = {nb_light, sb_light, eb_light, wb_light};
			nxt     = expected_next(cur_phase, model_pending);
			entered = 1'b0;
			lo      = window_lo(cur_phase);
			hi      = window_hi(cur_phase);
			if (held > 0) begin
				lo = lo - 2 * tick_div; // Tick grid is split by the hold
				hi = hi + 2 * tick_div;
			end
			if (shown == expected_lights(cur_phase)) begin
				in_phase = in_phase + 1;
				if (cur_phase == ew_green && emergency) begin
					held = held + 1;
				end
				assert (in_phase - held <= hi) else
					report_error($sformatf("%s stayed past %0d cycles", cur_phase.name(), hi));
			end else begin
				assert (shown == expected_lights(nxt)) else
					report_error($sformatf("lamps %h fit neither %s nor %s", shown,
						cur_phase.name(), nxt.name()));
				assert (in_phase - held >= lo) else
					report_error($sformatf("%s lasted only %0d cycles", cur_phase.name(),
						in_phase - held));
				entered   = (nxt == left_arrow);
				cur_phase = nxt;
				in_phase  = 1;
				held      = 0;
			end
			if (!key_seen) begin
				model_pending = 1'b1; // A press wins over the clear
			end else if (entered) begin
				model_pending = 1'b0;
			end
			assert (left_turn_pending == model_pending) else
				report_error($sformatf("left_turn_pending is %b, expected %b",
					left_turn_pending, model_pending));
			key_seen = left_turn_key;
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// Waits for the model to enter p within the current phase window plus a margin
	task automatic follow(input phase_t p);
		int limit;
		int n;
		limit = window_hi(cur_phase) + margin;
		n     = 0;
		while (cur_phase != p && n < limit) begin
			next_cycle();
			n = n + 1;
		end
		if (cur_phase != p) begin
			never_arrived(p);
		end
	endtask

	task automatic press_key();
		int pause;
		pause = $unsigned($random(seed)) % 32;
		repeat (pause) next_cycle();
		left_turn_key = 1'b0; // Low for a single edge
		next_cycle();
		left_turn_key = 1'b1;
		assert (left_turn_pending) else
			report_error("left turn request not latched after a key press");
	endtask

	initial begin
		reset         = 1'b0;
		left_turn_key = 1'b1;
		emergency     = 1'b0;
		monitor_on    = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		reset      = 1'b1;
		monitor_on = 1'b1;
		assert (eb_light == green && wb_light == green && nb_light == red &&
			sb_light == red && !left_turn_pending) else
			report_error("lamps after reset are not east-west green");

		repeat (2) begin // Plain cycles with no request
			follow(ew_yellow);
			follow(ew_all_red);
			follow(ns_green);
			follow(ns_yellow);
			follow(ns_all_red);
			follow(ew_green);
		end

		press_key(); // Request during east-west green
		follow(ew_yellow);
		follow(ew_all_red);
		follow(left_arrow);
		assert (sb_light == red_arrow && nb_light == red && eb_light == red &&
			wb_light == red && !left_turn_pending) else
			report_error("arrow phase lamps or request clear are wrong");
		follow(ns_green);
		follow(ns_yellow);
		follow(ns_all_red);
		follow(ew_green);

		repeat (3) next_cycle();
		emergency = 1'b1;
		for (int i = 0; i < 2 * `TL_GREEN_SEC * tick_div + 20; i++) begin
			next_cycle();
			assert (eb_light == green && wb_light == green) else
				report_error("east-west green ended while emergency was high");
		end
		emergency = 1'b0;
		follow(ew_yellow);
		follow(ew_all_red);
		follow(ns_green);

		press_key(); // Request during north-south green waits a whole cycle
		follow(ns_yellow);
		follow(ns_all_red);
		follow(ew_green);
		follow(ew_yellow);
		follow(ew_all_red);
		follow(left_arrow);
		follow(ns_green);

		$display("TEST PASS");
		$finish;
	end

endmodule
